/* bench/switch_props.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_props import switch_pkg::*; (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic [NUM_PORTS-1:0] wr_vld,
    input wire logic [NUM_PORTS-1:0] full,
    input wire logic [NUM_PORTS-1:0] almost_full,
    input wire logic [NUM_PORTS-1:0] rd_sop,
    input wire logic [NUM_PORTS-1:0] rd_eop,
    input wire logic [NUM_PORTS-1:0] rd_vld
);

    // host never writes into a full fifo
    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        (wr_vld & full) == '0)
        else $error("wr_vld high while full is high");

    full_has_almost_full: assert property (@(posedge clk) disable iff (reset)
        (full & ~almost_full) == '0)
        else $error("full high without almost_full");

    // framing flags only on valid words
    framing_needs_vld: assert property (@(posedge clk) disable iff (reset)
        ((rd_sop | rd_eop) & ~rd_vld) == '0)
        else $error("rd_sop or rd_eop without rd_vld");

endmodule

bind switch_top switch_props u_props (
    .clk         (clk),
    .reset       (reset),
    .wr_vld      (wr_vld),
    .full        (full),
    .almost_full (almost_full),
    .rd_sop      (rd_sop),
    .rd_eop      (rd_eop),
    .rd_vld      (rd_vld)
);

`default_nettype wire

/* bench/switch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_tb import switch_pkg::*; ();

    localparam int WAIT_LIMIT = 50000;
    localparam int NUM_KEYS = NUM_PORTS * NUM_PORTS;

    logic                  clk;
    logic                  reset;
    logic [NUM_PORTS-1:0]  wr_sop;
    logic [NUM_PORTS-1:0]  wr_eop;
    logic [NUM_PORTS-1:0]  wr_vld;
    data_t [NUM_PORTS-1:0] wr_data;
    logic [NUM_PORTS-1:0]  full;
    logic [NUM_PORTS-1:0]  almost_full;
    logic [NUM_PORTS-1:0]  ready;
    logic [NUM_PORTS-1:0]  rd_sop;
    logic [NUM_PORTS-1:0]  rd_eop;
    logic [NUM_PORTS-1:0]  rd_vld;
    data_t [NUM_PORTS-1:0] rd_data;

    integer seed = 32'hce25_69c1;
    int     errors = 0;
    int     checks = 0;
    int     sent = 0;
    int     received = 0;
    int     ready_mode = 0;
    int     track_port = -1;
    int     occ = 0;
    int     lens [7] = '{1, 7, 8, 9, 16, 17, 32};

    // expectations keyed by source * NUM_PORTS + destination
    int    exp_len [NUM_KEYS][$];
    data_t exp_words [NUM_KEYS][$];

    switch_top switch_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 0 all ready, 1 random, 2 all held low
    initial begin
        forever begin
            @(posedge clk);
            case (ready_mode)
                0: ready <= '1;
                1: ready <= NUM_PORTS'($random(seed));
                default: ready <= '0;
            endcase
        end
    end

    // words identical, destination from the header field
    function automatic port_t expected_route(input data_t pkt[$], output data_t words[$]);
        words = pkt;
        return pkt[0][DEST_LSB +: PORT_W];
    endfunction

    task automatic end_run();
        $display("checks %0d, errors %0d, packets sent %0d, received %0d",
                 checks, errors, sent, received);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        end_run();
    endtask

    task automatic check_flags(input int p, input int n);
        logic exp_af;
        logic exp_full;
        // fewer than a longest packet of entries left
        exp_af = n > (FIFO_DEPTH - MAX_PKT_WORDS);
        exp_full = (n == FIFO_DEPTH);
        checks++;
        if (almost_full[p] !== exp_af) begin
            $display("[FAIL] %0t almost_full[%0d]: expected %b, got %b",
                     $time, p, exp_af, almost_full[p]);
            errors++;
        end
        if (full[p] !== exp_full) begin
            $display("[FAIL] %0t full[%0d]: expected %b, got %b", $time, p, exp_full, full[p]);
            errors++;
        end
    endtask

    task automatic send_packet(input int p, input int dest, input int len);
        data_t pkt[$];
        data_t words[$];
        data_t w;
        port_t d;
        int    key;
        int    cnt;
        for (int i = 0; i < len; i++) begin
            w = data_t'($random(seed));
            if (i == 0) begin
                w[DEST_LSB +: PORT_W] = port_t'(dest);
                w[SRC_LSB +: PORT_W] = port_t'(p);
            end
            pkt.push_back(w);
        end
        d = expected_route(pkt, words);
        key = p * NUM_PORTS + int'(d);
        exp_len[key].push_back(len);
        foreach (words[i]) begin
            exp_words[key].push_back(words[i]);
        end
        sent++;
        // a packet may only start below almost_full
        cnt = 0;
        @(negedge clk);
        while (almost_full[p]) begin
            if (cnt == WAIT_LIMIT) begin
                timeout("almost_full to fall");
            end
            cnt++;
            @(negedge clk);
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            wr_vld[p] <= 1'b1;
            wr_sop[p] <= (i == 0);
            wr_eop[p] <= (i == len - 1);
            wr_data[p] <= pkt[i];
            // the word just driven is only taken at the next edge
            if (track_port == p) begin
                @(negedge clk);
                check_flags(p, occ);
                occ++;
            end
        end
        @(posedge clk);
        wr_vld[p] <= 1'b0;
        wr_sop[p] <= 1'b0;
        wr_eop[p] <= 1'b0;
    endtask

    task automatic port_traffic(input int p, input int n, input int min_len);
        int dest;
        int len;
        for (int k = 0; k < n; k++) begin
            dest = $unsigned($random(seed)) % NUM_PORTS;
            len = min_len + $unsigned($random(seed)) % (MAX_PKT_WORDS + 1 - min_len);
            send_packet(p, dest, len);
        end
    endtask

    task automatic run_traffic(input int n, input int min_len);
        fork
            port_traffic(0, n, min_len);
            port_traffic(1, n, min_len);
            port_traffic(2, n, min_len);
            port_traffic(3, n, min_len);
        join
    endtask

    task automatic compare_packet(input int p, input data_t got[$]);
        int key;
        int len;
        data_t w;
        key = int'(got[0][SRC_LSB +: PORT_W]) * NUM_PORTS + p;
        if (exp_len[key].size() == 0) begin
            $display("packet on port %0d from source %0d was never sent", p,
                     got[0][SRC_LSB +: PORT_W]);
            errors++;
            return;
        end
        len = exp_len[key].pop_front();
        checks++;
        if (len != got.size()) begin
            $display("[FAIL] %0t rd_data[%0d] length: expected %0d, got %0d",
                     $time, p, len, got.size());
            errors++;
        end
        for (int i = 0; i < len; i++) begin
            w = exp_words[key].pop_front();
            if (i < got.size() && got[i] !== w) begin
                $display("[FAIL] %0t rd_data[%0d] word %0d: expected %h, got %h",
                         $time, p, i, w, got[i]);
                errors++;
            end
        end
        received++;
    endtask

    // outputs are registered, so the falling edge sees them settled
    task automatic monitor_port(input int p);
        data_t got[$];
        logic  in_pkt;
        in_pkt = 1'b0;
        forever begin
            @(negedge clk);
            if (rd_vld[p]) begin
                if (rd_sop[p]) begin
                    if (in_pkt) begin
                        $display("sop inside a packet on port %0d at %0t", p, $time);
                        errors++;
                    end
                    got.delete();
                    in_pkt = 1'b1;
                end
                if (!in_pkt) begin
                    $display("word without sop on port %0d at %0t", p, $time);
                    errors++;
                end else begin
                    got.push_back(rd_data[p]);
                    if (rd_eop[p]) begin
                        compare_packet(p, got);
                        in_pkt = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (received != sent) begin
            if (cnt == WAIT_LIMIT) begin
                timeout("all packets to drain");
            end
            cnt++;
            @(negedge clk);
        end
    endtask

    // buffer out of pages and no transfer left in flight
    task automatic wait_buffer_full();
        int cnt;
        cnt = 0;
        while (switch_top_i.free_pages != '0 || switch_top_i.u_arbiter.busy) begin
            if (cnt == WAIT_LIMIT) begin
                timeout("the page buffer to fill");
            end
            cnt++;
            @(negedge clk);
        end
    endtask

    initial begin
        reset = 1'b1;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        ready = '1;
        fork
            monitor_port(0);
            monitor_port(1);
            monitor_port(2);
            monitor_port(3);
        join_none
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checks++;
        if (full !== '0 || almost_full !== '0 || rd_vld !== '0) begin
            $display("[FAIL] %0t full/almost_full/rd_vld: expected 0/0/0, got %h/%h/%h",
                     $time, full, almost_full, rd_vld);
            errors++;
        end
        send_packet(0, 2, 5);
        wait_drain();
        foreach (lens[i]) begin
            send_packet(1, $unsigned($random(seed)) % NUM_PORTS, lens[i]);
        end
        wait_drain();
        run_traffic(12, 1);
        wait_drain();
        ready_mode = 1;
        run_traffic(12, 1);
        wait_drain();
        // fill every page, then the fifo of port 0
        ready_mode = 2;
        for (int k = 0; k < NUM_PAGES / MAX_PKT_PAGES; k++) begin
            send_packet(0, $unsigned($random(seed)) % NUM_PORTS, MAX_PKT_WORDS);
        end
        wait_buffer_full();
        occ = 0;
        track_port = 0;
        send_packet(0, 1, MAX_PKT_WORDS);
        send_packet(0, 3, MAX_PKT_WORDS);
        track_port = -1;
        @(negedge clk);
        check_flags(0, occ);
        ready_mode = 0;
        wait_drain();
        // more than NUM_PAGES pages in total
        ready_mode = 1;
        run_traffic(10, 17);
        wait_drain();
        for (int k = 0; k < NUM_KEYS; k++) begin
            if (exp_len[k].size() != 0) begin
                $display("%0d packets from source %0d to port %0d never arrived",
                         exp_len[k].size(), k / NUM_PORTS, k % NUM_PORTS);
                errors++;
            end
        end
        end_run();
    end

endmodule

`default_nettype wire

/* logic/buf_rd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface buf_rd_if import switch_pkg::*; ();

    // queue state and read data from the buffer
    logic [NUM_PORTS-1:0] q_nonempty;
    page_t                head_page [NUM_PORTS];
    page_info_t           info;
    data_t                rd_data;

    // read requests from the egress side
    logic  rd_en;
    page_t rd_page;
    offs_t rd_offs;
    logic  page_release;
    logic  pop;
    port_t pop_port;

    modport buffer (
        output q_nonempty,
        output head_page,
        output info,
        output rd_data,
        input  rd_en,
        input  rd_page,
        input  rd_offs,
        input  page_release,
        input  pop,
        input  pop_port
    );

    modport reader (
        input  q_nonempty,
        input  head_page,
        input  info,
        input  rd_data,
        output rd_en,
        output rd_page,
        output rd_offs,
        output page_release,
        output pop,
        output pop_port
    );

endinterface

`default_nettype wire

/* logic/egress_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module egress_reader import switch_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] ready,
    output logic [NUM_PORTS-1:0] rd_sop,
    output logic [NUM_PORTS-1:0] rd_eop,
    output logic [NUM_PORTS-1:0] rd_vld,
    output data_t [NUM_PORTS-1:0] rd_data,
    buf_rd_if.reader buf_rd
);

    logic  busy;
    logic  first;
    port_t cur_port;
    port_t rr_ptr;
    page_t cur_page;
    offs_t cur_offs;
    port_t pick;
    logic  pick_vld;
    logic  issue;
    logic  last_word;
    logic  page_end;

    always_comb begin
        pick = rr_ptr;
        pick_vld = 1'b0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            if (buf_rd.q_nonempty[rr_ptr + port_t'(i)]) begin
                pick = rr_ptr + port_t'(i);
                pick_vld = 1'b1;
            end
        end
    end

    // one word per cycle while the current output is ready
    assign issue = busy & ready[cur_port];
    assign last_word = buf_rd.info.last & (cur_offs == buf_rd.info.last_offs);
    assign page_end = last_word | (cur_offs == offs_t'(PAGE_WORDS - 1));

    assign buf_rd.rd_en = issue;
    assign buf_rd.rd_page = cur_page;
    assign buf_rd.rd_offs = cur_offs;
    assign buf_rd.page_release = issue & page_end;
    assign buf_rd.pop = issue & last_word;
    assign buf_rd.pop_port = cur_port;

    // buffer data lines up with the registered valid
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_data[p] = rd_vld[p] ? buf_rd.rd_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            cur_page <= buf_rd.head_page[pick];
            cur_offs <= '0;
        end else if (issue) begin
            if (page_end) begin
                cur_page <= buf_rd.info.next;
                cur_offs <= '0;
            end else begin
                cur_offs <= cur_offs + offs_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            first    <= 1'b0;
            cur_port <= '0;
            rr_ptr   <= '0;
            rd_vld   <= '0;
            rd_sop   <= '0;
            rd_eop   <= '0;
        end else begin
            rd_vld <= '0;
            rd_sop <= '0;
            rd_eop <= '0;
            if (!busy) begin
                if (pick_vld) begin
                    busy     <= 1'b1;
                    first    <= 1'b1;
                    cur_port <= pick;
                end
            end else if (issue) begin
                rd_vld[cur_port] <= 1'b1;
                rd_sop[cur_port] <= first;
                rd_eop[cur_port] <= last_word;
                first <= 1'b0;
                // packet done, next search starts after this port
                if (last_word) begin
                    busy   <= 1'b0;
                    rr_ptr <= cur_port;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ingress_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module ingress_arbiter import switch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    pkt_stream_if.sink ports [NUM_PORTS],
    input  page_cnt_t free_pages,
    pkt_stream_if.src out
);

    logic [NUM_PORTS-1:0] avail_v;
    logic [NUM_PORTS-1:0] vld_v;
    logic [NUM_PORTS-1:0] sop_v;
    logic [NUM_PORTS-1:0] eop_v;
    data_t                data_v [NUM_PORTS];

    logic  busy;
    port_t sel;
    port_t pick;
    logic  pick_vld;
    logic  start;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign avail_v[i] = ports[i].avail;
        assign vld_v[i] = ports[i].vld;
        assign sop_v[i] = ports[i].sop;
        assign eop_v[i] = ports[i].eop;
        assign data_v[i] = ports[i].data;
        assign ports[i].grant = busy & (sel == port_t'(i));
    end

    // search starts after the last port served, sel itself comes last
    always_comb begin
        pick = sel;
        pick_vld = 1'b0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            if (avail_v[sel + port_t'(i)]) begin
                pick = sel + port_t'(i);
                pick_vld = 1'b1;
            end
        end
    end

    // room for a longest packet is reserved before the grant
    assign start = ~busy & pick_vld & out.grant & (free_pages >= page_cnt_t'(MAX_PKT_PAGES));

    assign out.vld = busy & vld_v[sel];
    assign out.sop = sop_v[sel];
    assign out.eop = eop_v[sel];
    assign out.data = data_v[sel];
    assign out.avail = |avail_v;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            sel  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            sel  <= pick;
        end else if (out.vld & out.eop) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/ingress_port.sv */
`timescale 1ns/100ps
`default_nettype none

module ingress_port import switch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_sop,
    input  logic  wr_eop,
    input  logic  wr_vld,
    input  data_t wr_data,
    output logic  full,
    output logic  almost_full,
    pkt_stream_if.src out
);

    // each entry keeps its framing flags next to the word
    logic [DATA_W+1:0] mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fifo_cnt_t          count;
    fifo_cnt_t          count_next;
    fifo_cnt_t          pkt_cnt;
    logic               push;
    logic               pop;

    assign push = wr_vld & ~full;

    // only complete packets are offered, so a granted stream has no gaps
    assign out.avail = (pkt_cnt != '0);
    assign pop = out.grant & out.avail;
    assign out.vld = pop;
    assign {out.sop, out.eop, out.data} = mem[rd_ptr];

    assign count_next = count + fifo_cnt_t'(push) - fifo_cnt_t'(pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_sop, wr_eop, wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            pkt_cnt     <= '0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // a packet counts once its eop word is stored
            pkt_cnt <= pkt_cnt + fifo_cnt_t'(push & wr_eop) - fifo_cnt_t'(pop & out.eop);
            full <= (count_next == fifo_cnt_t'(FIFO_DEPTH));
            // no room left for a longest packet
            almost_full <= (fifo_cnt_t'(FIFO_DEPTH) - count_next) < fifo_cnt_t'(MAX_PKT_WORDS);
        end
    end

endmodule

`default_nettype wire

/* logic/page_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module page_buffer import switch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    pkt_stream_if.sink wr,
    output page_cnt_t free_pages,
    buf_rd_if.buffer  rd
);

    data_t      mem [NUM_PAGES*PAGE_WORDS];
    page_info_t info_tab [NUM_PAGES];

    // bit set means the page is free
    logic [NUM_PAGES-1:0] free_map;
    page_cnt_t            free_cnt;
    page_t                free_low;

    // one queue per output port
    page_t     q_head [NUM_PORTS];
    page_t     q_tail [NUM_PORTS];
    page_cnt_t q_cnt [NUM_PORTS];

    logic  in_pkt;
    page_t cur_page;
    page_t first_page;
    port_t cur_dest;
    offs_t wr_offs;
    page_t w_page;
    offs_t w_offs;
    port_t pkt_dest;
    logic  need_page;
    logic  alloc;

    // append request, one cycle behind eop
    logic  app_vld;
    port_t app_dest;
    page_t app_first;
    page_t app_last;

    logic [NUM_PORTS-1:0] app_hit;
    logic [NUM_PORTS-1:0] pop_hit;
    data_t                rd_q;

    always_comb begin
        free_low = '0;
        for (int i = NUM_PAGES - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                free_low = page_t'(i);
            end
        end
    end

    // offset wraps to zero once a page holds PAGE_WORDS words
    assign need_page = wr.sop | (wr_offs == '0);
    assign alloc = wr.vld & need_page;
    assign w_page = need_page ? free_low : cur_page;
    assign w_offs = wr.sop ? '0 : wr_offs;
    assign pkt_dest = wr.sop ? wr.data[DEST_LSB +: PORT_W] : cur_dest;

    assign wr.grant = in_pkt | (wr.avail & (free_cnt >= page_cnt_t'(MAX_PKT_PAGES)));
    assign free_pages = free_cnt;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
        assign app_hit[p] = app_vld & (app_dest == port_t'(p));
        assign pop_hit[p] = rd.pop & (rd.pop_port == port_t'(p));
        assign rd.q_nonempty[p] = (q_cnt[p] != '0);
    end

    assign rd.head_page = q_head;
    assign rd.info = info_tab[rd.rd_page];
    assign rd.rd_data = rd_q;

    always_ff @(posedge clk) begin
        if (wr.vld) begin
            mem[{w_page, w_offs}] <= wr.data;
            cur_page <= w_page;
            cur_dest <= pkt_dest;
            if (wr.sop) begin
                first_page <= w_page;
            end
        end
        if (wr.vld & wr.eop) begin
            app_first <= wr.sop ? w_page : first_page;
            app_last  <= w_page;
            app_dest  <= pkt_dest;
        end
        if (rd.rd_en) begin
            rd_q <= mem[{rd.rd_page, rd.rd_offs}];
        end
    end

    // page chain inside a packet, and the jump from an old tail to a new packet
    always_ff @(posedge clk) begin
        if (alloc & ~wr.sop) begin
            info_tab[cur_page].next <= w_page;
        end
        if (wr.vld & (need_page | wr.eop)) begin
            info_tab[w_page].last      <= wr.eop;
            info_tab[w_page].last_offs <= w_offs;
        end
        if (app_vld & (q_cnt[app_dest] != '0)) begin
            info_tab[q_tail[app_dest]].next <= app_first;
        end
    end

    // rd_page is the popped packet's last page during pop
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pop_hit[p]) begin
                q_head[p] <= info_tab[rd.rd_page].next;
            end
            if (app_hit[p]) begin
                q_tail[p] <= app_last;
                if ((q_cnt[p] == '0) | (pop_hit[p] & (q_cnt[p] == page_cnt_t'(1)))) begin
                    q_head[p] <= app_first;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt   <= 1'b0;
            wr_offs  <= '0;
            app_vld  <= 1'b0;
            free_map <= '1;
            free_cnt <= page_cnt_t'(NUM_PAGES);
            for (int p = 0; p < NUM_PORTS; p++) begin
                q_cnt[p] <= '0;
            end
        end else begin
            app_vld <= wr.vld & wr.eop;
            if (wr.vld) begin
                in_pkt  <= ~wr.eop;
                wr_offs <= w_offs + offs_t'(1);
            end
            if (alloc) begin
                free_map[w_page] <= 1'b0;
            end
            if (rd.page_release) begin
                free_map[rd.rd_page] <= 1'b1;
            end
            free_cnt <= free_cnt - page_cnt_t'(alloc) + page_cnt_t'(rd.page_release);
            for (int p = 0; p < NUM_PORTS; p++) begin
                q_cnt[p] <= q_cnt[p] + page_cnt_t'(app_hit[p]) - page_cnt_t'(pop_hit[p]);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pkt_stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface pkt_stream_if import switch_pkg::*; ();

    logic  vld;
    logic  sop;
    logic  eop;
    data_t data;
    logic  avail;
    logic  grant;

    // source owns the packet words, sink hands out the grant
    modport src (
        output vld,
        output sop,
        output eop,
        output data,
        output avail,
        input  grant
    );

    modport sink (
        input  vld,
        input  sop,
        input  eop,
        input  data,
        input  avail,
        output grant
    );

endinterface

`default_nettype wire

/* logic/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    // port side
    localparam int NUM_PORTS = 4;
    localparam int PORT_W = 2;
    localparam int DATA_W = 16;

    // shared paged buffer
    localparam int PAGE_WORDS = 8;
    localparam int OFFS_W = 3;
    localparam int NUM_PAGES = 64;
    localparam int PAGE_W = 6;

    // packet limits, header word included
    localparam int MAX_PKT_WORDS = 32;
    localparam int MAX_PKT_PAGES = 4;

    // ingress fifo
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW = 6;

    // header field positions, both fields PORT_W wide
    localparam int DEST_LSB = 0;
    localparam int SRC_LSB = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PORT_W-1:0] port_t;
    typedef logic [PAGE_W-1:0] page_t;
    typedef logic [OFFS_W-1:0] offs_t;

    // one extra bit so a full pool or a full fifo can be counted
    typedef logic [PAGE_W:0] page_cnt_t;
    typedef logic [FIFO_AW:0] fifo_cnt_t;

    // next doubles as the link to the following packet in a queue
    typedef struct packed {
        page_t next;
        logic  last;
        offs_t last_offs;
    } page_info_t;

endpackage

`default_nettype wire

/* logic/switch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_top import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_PORTS-1:0]  wr_sop,
    input  logic [NUM_PORTS-1:0]  wr_eop,
    input  logic [NUM_PORTS-1:0]  wr_vld,
    input  data_t [NUM_PORTS-1:0] wr_data,
    output logic [NUM_PORTS-1:0]  full,
    output logic [NUM_PORTS-1:0]  almost_full,
    input  logic [NUM_PORTS-1:0]  ready,
    output logic [NUM_PORTS-1:0]  rd_sop,
    output logic [NUM_PORTS-1:0]  rd_eop,
    output logic [NUM_PORTS-1:0]  rd_vld,
    output data_t [NUM_PORTS-1:0] rd_data
);

    page_cnt_t free_pages;

    pkt_stream_if port_if [NUM_PORTS] ();
    pkt_stream_if buf_if ();
    buf_rd_if     rd_if ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ingress
        ingress_port u_port (
            .clk         (clk),
            .reset       (reset),
            .wr_sop      (wr_sop[i]),
            .wr_eop      (wr_eop[i]),
            .wr_vld      (wr_vld[i]),
            .wr_data     (wr_data[i]),
            .full        (full[i]),
            .almost_full (almost_full[i]),
            .out         (port_if[i])
        );
    end

    ingress_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .ports      (port_if),
        .free_pages (free_pages),
        .out        (buf_if)
    );

    page_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .wr         (buf_if),
        .free_pages (free_pages),
        .rd         (rd_if)
    );

    egress_reader u_egress (
        .clk     (clk),
        .reset   (reset),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .buf_rd  (rd_if)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module switch_tb -f tb.f -o switch_sim

./obj_dir/switch_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

/* tb.f */
logic/switch_pkg.sv
logic/pkt_stream_if.sv
logic/buf_rd_if.sv
logic/ingress_port.sv
logic/ingress_arbiter.sv
logic/page_buffer.sv
logic/egress_reader.sv
logic/switch_top.sv
bench/switch_props.sv
bench/switch_tb.sv
